//--- verilog/axi_sub_settings.svh
`ifndef AXI_SUB_SETTINGS_SVH
`define AXI_SUB_SETTINGS_SVH

// AXI field widths
`define AXI_ID_W    4
`define AXI_ADDR_W  32
`define AXI_DATA_W  32
`define AXI_STRB_W  (`AXI_DATA_W / 8)
`define AXI_LEN_W   8
`define AXI_SIZE_W  3
`define AXI_BURST_W 2
`define AXI_RESP_W  2

// Masters sharing the SRAM, 2 to 4
`define PORT_NUM 2

// Depth in words, power of two
`define SRAM_WORDS 256

`endif

//--- verilog/axi_sub_pkg.sv
`default_nettype none

`include "axi_sub_settings.svh"

package axi_sub_pkg;

	typedef enum logic [`AXI_RESP_W-1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_t;

	// WRAP is accepted but stepped like INCR
	typedef enum logic [`AXI_BURST_W-1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} axi_burst_t;

	// At least one bit, even for a single port
	localparam int PORT_IDX_W = (`PORT_NUM > 1) ? $clog2(`PORT_NUM) : 1;

	typedef logic [PORT_IDX_W-1:0] port_idx_t;

endpackage

`default_nettype wire

//--- verilog/axi_bus.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_sub_settings.svh"

interface axi_bus;
	import axi_sub_pkg::*;

	// Write address
	logic [`AXI_ID_W-1:0]   awid;
	logic [`AXI_ADDR_W-1:0] awaddr;
	logic [`AXI_LEN_W-1:0]  awlen;
	logic [`AXI_SIZE_W-1:0] awsize;
	axi_burst_t             awburst;
	logic                   awvalid;
	logic                   awready;

	// Write data
	logic [`AXI_ID_W-1:0]   wid;
	logic [`AXI_DATA_W-1:0] wdata;
	logic [`AXI_STRB_W-1:0] wstrb;
	logic                   wlast;
	logic                   wvalid;
	logic                   wready;

	// Write response
	logic [`AXI_ID_W-1:0]   bid;
	axi_resp_t              bresp;
	logic                   bvalid;
	logic                   bready;

	// Read address
	logic [`AXI_ID_W-1:0]   arid;
	logic [`AXI_ADDR_W-1:0] araddr;
	logic [`AXI_LEN_W-1:0]  arlen;
	logic [`AXI_SIZE_W-1:0] arsize;
	axi_burst_t             arburst;
	logic                   arvalid;
	logic                   arready;

	// Read data
	logic [`AXI_ID_W-1:0]   rid;
	logic [`AXI_DATA_W-1:0] rdata;
	axi_resp_t              rresp;
	logic                   rlast;
	logic                   rvalid;
	logic                   rready;

	modport master (
		output awid, awaddr, awlen, awsize, awburst, awvalid,
		input  awready,
		output wid, wdata, wstrb, wlast, wvalid,
		input  wready,
		input  bid, bresp, bvalid,
		output bready,
		output arid, araddr, arlen, arsize, arburst, arvalid,
		input  arready,
		input  rid, rdata, rresp, rlast, rvalid,
		output rready
	);

	modport slave (
		input  awid, awaddr, awlen, awsize, awburst, awvalid,
		output awready,
		input  wid, wdata, wstrb, wlast, wvalid,
		output wready,
		output bid, bresp, bvalid,
		input  bready,
		input  arid, araddr, arlen, arsize, arburst, arvalid,
		output arready,
		output rid, rdata, rresp, rlast, rvalid,
		input  rready
	);

endinterface

`default_nettype wire

//--- verilog/axi_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_sub_settings.svh"

module axi_mux (
	input  logic aclk,
	input  logic aresetn,

	// Write address
	input  logic [`AXI_ID_W*`PORT_NUM-1:0]    s_awid,
	input  logic [`AXI_ADDR_W*`PORT_NUM-1:0]  s_awaddr,
	input  logic [`AXI_LEN_W*`PORT_NUM-1:0]   s_awlen,
	input  logic [`AXI_SIZE_W*`PORT_NUM-1:0]  s_awsize,
	input  logic [`AXI_BURST_W*`PORT_NUM-1:0] s_awburst,
	input  logic [`PORT_NUM-1:0]              s_awvalid,
	output logic [`PORT_NUM-1:0]              s_awready,

	// Write data
	input  logic [`AXI_ID_W*`PORT_NUM-1:0]    s_wid,
	input  logic [`AXI_DATA_W*`PORT_NUM-1:0]  s_wdata,
	input  logic [`AXI_STRB_W*`PORT_NUM-1:0]  s_wstrb,
	input  logic [`PORT_NUM-1:0]              s_wlast,
	input  logic [`PORT_NUM-1:0]              s_wvalid,
	output logic [`PORT_NUM-1:0]              s_wready,

	// Write response
	input  logic [`PORT_NUM-1:0]              s_bready,
	output logic [`AXI_ID_W*`PORT_NUM-1:0]    s_bid,
	output logic [`AXI_RESP_W*`PORT_NUM-1:0]  s_bresp,
	output logic [`PORT_NUM-1:0]              s_bvalid,

	// Read address
	input  logic [`AXI_ID_W*`PORT_NUM-1:0]    s_arid,
	input  logic [`AXI_ADDR_W*`PORT_NUM-1:0]  s_araddr,
	input  logic [`AXI_LEN_W*`PORT_NUM-1:0]   s_arlen,
	input  logic [`AXI_SIZE_W*`PORT_NUM-1:0]  s_arsize,
	input  logic [`AXI_BURST_W*`PORT_NUM-1:0] s_arburst,
	input  logic [`PORT_NUM-1:0]              s_arvalid,
	output logic [`PORT_NUM-1:0]              s_arready,

	// Read data
	input  logic [`PORT_NUM-1:0]              s_rready,
	output logic [`AXI_ID_W*`PORT_NUM-1:0]    s_rid,
	output logic [`AXI_DATA_W*`PORT_NUM-1:0]  s_rdata,
	output logic [`AXI_RESP_W*`PORT_NUM-1:0]  s_rresp,
	output logic [`PORT_NUM-1:0]              s_rlast,
	output logic [`PORT_NUM-1:0]              s_rvalid,

	axi_bus.master m,

	output logic wr_busy,
	output logic rd_busy
);
	import axi_sub_pkg::*;

	port_idx_t wr_grant;
	logic      wr_dis;
	port_idx_t rd_grant;
	logic      rd_dis;

	// First requester above the last grant, wrapping around
	function automatic port_idx_t rr_pick(input port_idx_t last, input logic [`PORT_NUM-1:0] req);
		int        idx;
		port_idx_t pick;
		logic      found;
		pick  = last;
		found = 1'b0;
		for (int i = 1; i <= `PORT_NUM; i++) begin
			idx = (int'(last) + i) % `PORT_NUM;
			if (!found && req[idx]) begin
				pick  = port_idx_t'(idx);
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	// Write side, held from grant to B handshake
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_busy  <= 1'b0;
			wr_dis   <= 1'b0;
			wr_grant <= port_idx_t'(`PORT_NUM - 1);
		end else if (!wr_busy) begin
			wr_grant <= rr_pick(wr_grant, s_awvalid);
			if (|s_awvalid)
				wr_busy <= 1'b1;
		end else if (m.bvalid && m.bready) begin
			wr_busy <= 1'b0;
			wr_dis  <= 1'b0;
		end else if (m.awvalid && m.awready) begin
			wr_dis <= 1'b1;
		end
	end

	always_comb begin
		m.awid    = s_awid[wr_grant*`AXI_ID_W +: `AXI_ID_W];
		m.awaddr  = s_awaddr[wr_grant*`AXI_ADDR_W +: `AXI_ADDR_W];
		m.awlen   = s_awlen[wr_grant*`AXI_LEN_W +: `AXI_LEN_W];
		m.awsize  = s_awsize[wr_grant*`AXI_SIZE_W +: `AXI_SIZE_W];
		m.awburst = axi_burst_t'(s_awburst[wr_grant*`AXI_BURST_W +: `AXI_BURST_W]);
		// AW goes out once per grant
		m.awvalid = wr_busy & s_awvalid[wr_grant] & ~wr_dis;

		m.wid    = s_wid[wr_grant*`AXI_ID_W +: `AXI_ID_W];
		m.wdata  = s_wdata[wr_grant*`AXI_DATA_W +: `AXI_DATA_W];
		m.wstrb  = s_wstrb[wr_grant*`AXI_STRB_W +: `AXI_STRB_W];
		m.wlast  = s_wlast[wr_grant];
		m.wvalid = wr_busy & s_wvalid[wr_grant];
		m.bready = s_bready[wr_grant];

		for (int i = 0; i < `PORT_NUM; i++) begin
			s_awready[i] = wr_busy && (wr_grant == i) && m.awready && !wr_dis;
			s_wready[i]  = wr_busy && (wr_grant == i) && m.wready;
			s_bvalid[i]  = wr_busy && (wr_grant == i) && m.bvalid;
		end

		// Payload to everyone, valid only to the owner
		s_bid   = {`PORT_NUM{m.bid}};
		s_bresp = {`PORT_NUM{m.bresp}};
	end

	// Read side, held from grant to last R beat
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			rd_busy  <= 1'b0;
			rd_dis   <= 1'b0;
			rd_grant <= port_idx_t'(`PORT_NUM - 1);
		end else if (!rd_busy) begin
			rd_grant <= rr_pick(rd_grant, s_arvalid);
			if (|s_arvalid)
				rd_busy <= 1'b1;
		end else if (m.rvalid && m.rready && m.rlast) begin
			rd_busy <= 1'b0;
			rd_dis  <= 1'b0;
		end else if (m.arvalid && m.arready) begin
			rd_dis <= 1'b1;
		end
	end

	always_comb begin
		m.arid    = s_arid[rd_grant*`AXI_ID_W +: `AXI_ID_W];
		m.araddr  = s_araddr[rd_grant*`AXI_ADDR_W +: `AXI_ADDR_W];
		m.arlen   = s_arlen[rd_grant*`AXI_LEN_W +: `AXI_LEN_W];
		m.arsize  = s_arsize[rd_grant*`AXI_SIZE_W +: `AXI_SIZE_W];
		m.arburst = axi_burst_t'(s_arburst[rd_grant*`AXI_BURST_W +: `AXI_BURST_W]);
		m.arvalid = rd_busy & s_arvalid[rd_grant] & ~rd_dis;
		m.rready  = s_rready[rd_grant];

		for (int i = 0; i < `PORT_NUM; i++) begin
			s_arready[i] = rd_busy && (rd_grant == i) && m.arready && !rd_dis;
			s_rvalid[i]  = rd_busy && (rd_grant == i) && m.rvalid;
		end

		s_rid   = {`PORT_NUM{m.rid}};
		s_rdata = {`PORT_NUM{m.rdata}};
		s_rresp = {`PORT_NUM{m.rresp}};
		s_rlast = {`PORT_NUM{m.rlast}};
	end

endmodule

`default_nettype wire

//--- verilog/axi_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_sub_settings.svh"

module axi_sram (
	input  logic aclk,
	input  logic aresetn,
	axi_bus.slave s
);
	import axi_sub_pkg::*;

	localparam int WORD_W = $clog2(`SRAM_WORDS);
	localparam int OFS_W  = $clog2(`AXI_STRB_W);

	logic [`AXI_DATA_W-1:0] mem [`SRAM_WORDS];

	// Write engine
	logic                   wr_act;
	logic                   b_pend;
	logic [`AXI_LEN_W-1:0]  wr_cnt;
	logic [`AXI_LEN_W-1:0]  wr_len;
	logic [WORD_W-1:0]      wr_addr;
	logic [`AXI_ID_W-1:0]   wr_id;
	axi_burst_t             wr_burst;
	logic                   aw_hs;
	logic                   w_hs;
	logic                   w_end;

	// Read engine
	logic                   rd_valid;
	logic                   rd_last;
	logic [`AXI_LEN_W-1:0]  rd_cnt;
	logic [`AXI_LEN_W-1:0]  rd_len;
	logic [WORD_W-1:0]      rd_addr;
	logic [`AXI_ID_W-1:0]   rd_id;
	axi_burst_t             rd_burst;
	logic [`AXI_DATA_W-1:0] rd_data;
	logic [WORD_W-1:0]      ar_word;
	logic [WORD_W-1:0]      rd_fetch;
	logic                   ar_hs;
	logic                   r_hs;

	function automatic logic [WORD_W-1:0] step_word(input logic [WORD_W-1:0] word,
			input axi_burst_t burst);
		return (burst == BURST_FIXED) ? word : word + 1'b1;
	endfunction

	assign aw_hs = s.awvalid && s.awready;
	assign w_hs  = s.wvalid && s.wready;
	// Beat count also ends the burst if WLAST never comes
	assign w_end = w_hs && (s.wlast || wr_cnt == wr_len);

	assign s.awready = !wr_act && !b_pend;
	assign s.wready  = wr_act;
	assign s.bvalid  = b_pend;
	assign s.bid     = wr_id;
	assign s.bresp   = RESP_OKAY;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_act <= 1'b0;
			b_pend <= 1'b0;
			wr_cnt <= '0;
		end else if (aw_hs) begin
			wr_act <= 1'b1;
			wr_cnt <= '0;
		end else if (w_hs) begin
			wr_cnt <= wr_cnt + 1'b1;
			if (w_end) begin
				wr_act <= 1'b0;
				b_pend <= 1'b1;
			end
		end else if (b_pend && s.bready) begin
			b_pend <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (aw_hs) begin
			wr_addr  <= s.awaddr[OFS_W +: WORD_W];
			wr_id    <= s.awid;
			wr_burst <= s.awburst;
			wr_len   <= s.awlen;
		end else if (w_hs) begin
			wr_addr <= step_word(wr_addr, wr_burst);
		end
	end

	// Byte merge under the strobes
	always_ff @(posedge aclk) begin
		if (w_hs) begin
			for (int b = 0; b < `AXI_STRB_W; b++) begin
				if (s.wstrb[b])
					mem[wr_addr][8*b +: 8] <= s.wdata[8*b +: 8];
			end
		end
	end

	assign ar_hs    = s.arvalid && s.arready;
	assign r_hs     = rd_valid && s.rready;
	assign ar_word  = s.araddr[OFS_W +: WORD_W];
	assign rd_fetch = ar_hs ? ar_word : rd_addr;

	assign s.arready = !rd_valid;
	assign s.rvalid  = rd_valid;
	assign s.rlast   = rd_last;
	assign s.rid     = rd_id;
	assign s.rdata   = rd_data;
	assign s.rresp   = RESP_OKAY;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			rd_valid <= 1'b0;
			rd_last  <= 1'b0;
			rd_cnt   <= '0;
		end else if (ar_hs) begin
			rd_valid <= 1'b1;
			rd_last  <= (s.arlen == '0);
			rd_cnt   <= '0;
		end else if (r_hs) begin
			if (rd_last) begin
				rd_valid <= 1'b0;
				rd_last  <= 1'b0;
			end else begin
				rd_cnt  <= rd_cnt + 1'b1;
				rd_last <= (rd_cnt + 1'b1 == rd_len);
			end
		end
	end

	// Next beat is fetched on the accepting edge, so beats stream back to back
	always_ff @(posedge aclk) begin
		if (ar_hs || (r_hs && !rd_last))
			rd_data <= mem[rd_fetch];
		if (ar_hs) begin
			rd_addr  <= step_word(ar_word, s.arburst);
			rd_id    <= s.arid;
			rd_burst <= s.arburst;
			rd_len   <= s.arlen;
		end else if (r_hs && !rd_last) begin
			rd_addr <= step_word(rd_addr, rd_burst);
		end
	end

endmodule

`default_nettype wire

//--- verilog/axi_sub_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_sub_settings.svh"

module axi_sub_top (
	input  logic aclk,
	input  logic aresetn,

	// Write address
	input  logic [`AXI_ID_W*`PORT_NUM-1:0]    s_awid,
	input  logic [`AXI_ADDR_W*`PORT_NUM-1:0]  s_awaddr,
	input  logic [`AXI_LEN_W*`PORT_NUM-1:0]   s_awlen,
	input  logic [`AXI_SIZE_W*`PORT_NUM-1:0]  s_awsize,
	input  logic [`AXI_BURST_W*`PORT_NUM-1:0] s_awburst,
	input  logic [`PORT_NUM-1:0]              s_awvalid,
	output logic [`PORT_NUM-1:0]              s_awready,

	// Write data
	input  logic [`AXI_ID_W*`PORT_NUM-1:0]    s_wid,
	input  logic [`AXI_DATA_W*`PORT_NUM-1:0]  s_wdata,
	input  logic [`AXI_STRB_W*`PORT_NUM-1:0]  s_wstrb,
	input  logic [`PORT_NUM-1:0]              s_wlast,
	input  logic [`PORT_NUM-1:0]              s_wvalid,
	output logic [`PORT_NUM-1:0]              s_wready,

	// Write response
	input  logic [`PORT_NUM-1:0]              s_bready,
	output logic [`AXI_ID_W*`PORT_NUM-1:0]    s_bid,
	output logic [`AXI_RESP_W*`PORT_NUM-1:0]  s_bresp,
	output logic [`PORT_NUM-1:0]              s_bvalid,

	// Read address
	input  logic [`AXI_ID_W*`PORT_NUM-1:0]    s_arid,
	input  logic [`AXI_ADDR_W*`PORT_NUM-1:0]  s_araddr,
	input  logic [`AXI_LEN_W*`PORT_NUM-1:0]   s_arlen,
	input  logic [`AXI_SIZE_W*`PORT_NUM-1:0]  s_arsize,
	input  logic [`AXI_BURST_W*`PORT_NUM-1:0] s_arburst,
	input  logic [`PORT_NUM-1:0]              s_arvalid,
	output logic [`PORT_NUM-1:0]              s_arready,

	// Read data
	input  logic [`PORT_NUM-1:0]              s_rready,
	output logic [`AXI_ID_W*`PORT_NUM-1:0]    s_rid,
	output logic [`AXI_DATA_W*`PORT_NUM-1:0]  s_rdata,
	output logic [`AXI_RESP_W*`PORT_NUM-1:0]  s_rresp,
	output logic [`PORT_NUM-1:0]              s_rlast,
	output logic [`PORT_NUM-1:0]              s_rvalid,

	// Debug
	output logic wr_busy,
	output logic rd_busy
);

	// Single shared bus between arbiter and SRAM
	axi_bus sram_bus ();

	axi_mux u_axi_mux (
		.aclk,
		.aresetn,
		.s_awid, .s_awaddr, .s_awlen, .s_awsize, .s_awburst, .s_awvalid, .s_awready,
		.s_wid, .s_wdata, .s_wstrb, .s_wlast, .s_wvalid, .s_wready,
		.s_bready, .s_bid, .s_bresp, .s_bvalid,
		.s_arid, .s_araddr, .s_arlen, .s_arsize, .s_arburst, .s_arvalid, .s_arready,
		.s_rready, .s_rid, .s_rdata, .s_rresp, .s_rlast, .s_rvalid,
		.m       (sram_bus.master),
		.wr_busy,
		.rd_busy
	);

	axi_sram u_axi_sram (
		.aclk,
		.aresetn,
		.s       (sram_bus.slave)
	);

endmodule

`default_nettype wire

//--- sim/tb_axi_sub_tasks.svh
`ifndef TB_AXI_SUB_TASKS_SVH
`define TB_AXI_SUB_TASKS_SVH

// AW or AR on one port, held until the handshake
task automatic addr_send(input logic rd, input int p, input logic [`AXI_ID_W-1:0] id,
		input logic [`AXI_ADDR_W-1:0] addr, input int len, input axi_burst_t burst);
	int n;
	#1;
	if (rd) begin
		s_arid[p*`AXI_ID_W +: `AXI_ID_W]          = id;
		s_araddr[p*`AXI_ADDR_W +: `AXI_ADDR_W]    = addr;
		s_arlen[p*`AXI_LEN_W +: `AXI_LEN_W]       = len[`AXI_LEN_W-1:0];
		s_arsize[p*`AXI_SIZE_W +: `AXI_SIZE_W]    = 3'd2;
		s_arburst[p*`AXI_BURST_W +: `AXI_BURST_W] = burst;
		s_arvalid[p] = 1'b1;
	end else begin
		s_awid[p*`AXI_ID_W +: `AXI_ID_W]          = id;
		s_awaddr[p*`AXI_ADDR_W +: `AXI_ADDR_W]    = addr;
		s_awlen[p*`AXI_LEN_W +: `AXI_LEN_W]       = len[`AXI_LEN_W-1:0];
		s_awsize[p*`AXI_SIZE_W +: `AXI_SIZE_W]    = 3'd2;
		s_awburst[p*`AXI_BURST_W +: `AXI_BURST_W] = burst;
		s_awvalid[p] = 1'b1;
	end
	n = 0;
	@(posedge aclk);
	while (!(rd ? s_arready[p] : s_awready[p])) begin
		n++;
		if (n > TIMEOUT)
			report_timeout("address handshake");
		@(posedge aclk);
	end
	grant_order.push_back(p);
	#1;
	if (rd)
		s_arvalid[p] = 1'b0;
	else
		s_awvalid[p] = 1'b0;
	@(posedge aclk);
endtask

// W beats with random data, merged into the model as they are accepted
task automatic w_send(input int p, input logic [`AXI_ID_W-1:0] id,
		input logic [`AXI_ADDR_W-1:0] addr, input int len, input axi_burst_t burst,
		input logic mixed);
	int          word;
	int          n;
	logic [31:0] data;
	logic [31:0] strb;
	word = (addr >> 2) % `SRAM_WORDS;
	for (int beat = 0; beat <= len; beat++) begin
		rand_bits(32, data);
		strb = 32'hf;
		if (mixed)
			rand_bits(`AXI_STRB_W, strb);
		#1;
		s_wid[p*`AXI_ID_W +: `AXI_ID_W]       = id;
		s_wdata[p*`AXI_DATA_W +: `AXI_DATA_W] = data;
		s_wstrb[p*`AXI_STRB_W +: `AXI_STRB_W] = strb[`AXI_STRB_W-1:0];
		s_wlast[p]  = (beat == len);
		s_wvalid[p] = 1'b1;
		n = 0;
		@(posedge aclk);
		while (!s_wready[p]) begin
			n++;
			if (n > TIMEOUT)
				report_timeout("W handshake");
			@(posedge aclk);
		end
		for (int b = 0; b < `AXI_STRB_W; b++) begin
			if (strb[b])
				ref_mem[word][8*b +: 8] = data[8*b +: 8];
		end
		if (burst != BURST_FIXED)
			word = (word + 1) % `SRAM_WORDS;
	end
	#1;
	s_wvalid[p] = 1'b0;
	s_wlast[p]  = 1'b0;
	@(posedge aclk);
endtask

task automatic b_wait(input int p, input logic [`AXI_ID_W-1:0] id);
	int n;
	#1 s_bready[p] = 1'b1;
	n = 0;
	@(posedge aclk);
	while (!s_bvalid[p]) begin
		n++;
		if (n > TIMEOUT)
			report_timeout("B response");
		@(posedge aclk);
	end
	check("bid", id, s_bid[p*`AXI_ID_W +: `AXI_ID_W]);
	check("bresp", RESP_OKAY, s_bresp[p*`AXI_RESP_W +: `AXI_RESP_W]);
	#1 s_bready[p] = 1'b0;
	@(posedge aclk);
endtask

// Optional random RREADY drops while collecting beats
task automatic r_recv(input int p, input logic [`AXI_ID_W-1:0] id,
		input logic [`AXI_ADDR_W-1:0] addr, input int len, input axi_burst_t burst,
		input logic stall);
	int          word;
	int          beat;
	int          n;
	logic [31:0] rdy;
	word = (addr >> 2) % `SRAM_WORDS;
	beat = 0;
	n    = 0;
	while (beat <= len) begin
		rdy = 32'h1;
		if (stall)
			rand_bits(1, rdy);
		#1 s_rready[p] = rdy[0];
		@(posedge aclk);
		if (s_rvalid[p] && s_rready[p]) begin
			check("rdata", ref_mem[word], s_rdata[p*`AXI_DATA_W +: `AXI_DATA_W]);
			check("rid", id, s_rid[p*`AXI_ID_W +: `AXI_ID_W]);
			check("rresp", RESP_OKAY, s_rresp[p*`AXI_RESP_W +: `AXI_RESP_W]);
			check("rlast", beat == len, s_rlast[p]);
			if (burst != BURST_FIXED)
				word = (word + 1) % `SRAM_WORDS;
			beat++;
			n = 0;
		end else begin
			n++;
			if (n > TIMEOUT)
				report_timeout("R beat");
		end
	end
	#1 s_rready[p] = 1'b0;
	@(posedge aclk);
	check("rvalid after last", 0, s_rvalid[p]);
endtask

task automatic write_burst(input int p, input logic [`AXI_ID_W-1:0] id,
		input logic [`AXI_ADDR_W-1:0] addr, input int len, input axi_burst_t burst,
		input logic mixed);
	addr_send(1'b0, p, id, addr, len, burst);
	w_send(p, id, addr, len, burst, mixed);
	b_wait(p, id);
endtask

task automatic read_burst(input int p, input logic [`AXI_ID_W-1:0] id,
		input logic [`AXI_ADDR_W-1:0] addr, input int len, input axi_burst_t burst,
		input logic stall);
	addr_send(1'b1, p, id, addr, len, burst);
	r_recv(p, id, addr, len, burst, stall);
endtask

task automatic test_reset_state;
	test_name = "reset_state";
	check("wr_busy", 0, wr_busy);
	check("rd_busy", 0, rd_busy);
	check("ready outputs", 0, {s_awready, s_wready, s_arready});
	check("valid outputs", 0, {s_bvalid, s_rvalid});
	for (int p = 0; p < P; p++) begin
		write_burst(p, 4'(p + 3), 32'h10 + 32'(p * 16), 0, BURST_INCR, 1'b0);
		read_burst(p, 4'(p + 8), 32'h10 + 32'(p * 16), 0, BURST_INCR, 1'b0);
	end
endtask

task automatic test_bursts;
	test_name = "incr_burst";
	// Full-strobe fill first so merged bytes are all known
	write_burst(0, 4'h1, 32'h100, 7, BURST_INCR, 1'b0);
	write_burst(1, 4'h2, 32'h100, 7, BURST_INCR, 1'b1);
	read_burst(0, 4'h3, 32'h100, 7, BURST_INCR, 1'b0);
	test_name = "fixed_burst";
	write_burst(1, 4'h4, 32'h200, 0, BURST_INCR, 1'b0);
	write_burst(0, 4'h5, 32'h200, 3, BURST_FIXED, 1'b1);
	read_burst(1, 4'h6, 32'h200, 3, BURST_FIXED, 1'b0);
endtask

task automatic rr_xfer(input logic rd, input int p);
	logic [`AXI_ADDR_W-1:0] addr;
	addr = 32'h300 + 32'(p * 64);
	if (rd)
		read_burst(p, 4'(p + 1), addr, 1, BURST_INCR, 1'b0);
	else
		write_burst(p, 4'(p + 1), addr, 1, BURST_INCR, 1'b0);
endtask

// Requests start in the same cycle; first is the expected winner
task automatic rr_round(input logic rd, input logic [1:0] req, input int first);
	grant_order.delete();
	fork
		if (req[0]) rr_xfer(rd, 0);
		if (req[1]) rr_xfer(rd, 1);
	join
	if (req == 2'b11)
		check("first grant", first, grant_order[0]);
endtask

task automatic test_round_robin;
	test_name = "round_robin";
	apply_reset();
	rr_round(1'b0, 2'b11, 0);
	rr_round(1'b0, 2'b11, 0);
	rr_round(1'b0, 2'b01, 0);
	rr_round(1'b0, 2'b11, 1);
	rr_round(1'b1, 2'b11, 0);
	rr_round(1'b1, 2'b01, 0);
	rr_round(1'b1, 2'b11, 1);
endtask

task automatic test_grant_isolation;
	int n;
	test_name = "grant_isolation";
	fork
		write_burst(0, 4'h9, 32'h080, 3, BURST_INCR, 1'b1);
		begin
			repeat (2) @(posedge aclk);
			write_burst(1, 4'ha, 32'h0a0, 0, BURST_INCR, 1'b0);
		end
		begin
			n = 0;
			@(posedge aclk);
			while (!wr_busy) begin
				n++;
				if (n > TIMEOUT)
					report_timeout("write grant");
				@(posedge aclk);
			end
			n = 0;
			// Port 0 owns the write side here
			while (!(s_bvalid[0] && s_bready[0])) begin
				check("port 1 awready", 0, s_awready[1]);
				check("port 1 wready", 0, s_wready[1]);
				check("port 1 bvalid", 0, s_bvalid[1]);
				check("wr_busy", 1, wr_busy);
				n++;
				if (n > TIMEOUT)
					report_timeout("B handshake on port 0");
				@(posedge aclk);
			end
			@(posedge aclk);
			check("wr_busy after B", 0, wr_busy);
		end
	join
	read_burst(1, 4'hb, 32'h080, 3, BURST_INCR, 1'b0);
endtask

task automatic test_independent_sides;
	test_name = "independent_sides";
	// BREADY stays low so the write side remains busy
	addr_send(1'b0, 0, 4'hc, 32'h3c0, 1, BURST_INCR);
	w_send(0, 4'hc, 32'h3c0, 1, BURST_INCR, 1'b0);
	read_burst(1, 4'hd, 32'h100, 7, BURST_INCR, 1'b0);
	check("bvalid held", 1, s_bvalid[0]);
	check("wr_busy held", 1, wr_busy);
	b_wait(0, 4'hc);
	test_name = "read_backpressure";
	read_burst(1, 4'he, 32'h100, 7, BURST_INCR, 1'b1);
	read_burst(0, 4'hf, 32'h3c0, 1, BURST_INCR, 1'b1);
endtask

`endif

//--- sim/tb_axi_sub.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_sub_settings.svh"

module tb_axi_sub;
	import axi_sub_pkg::*;

	localparam int P       = `PORT_NUM;
	localparam int TIMEOUT = 1000;

	logic aclk;
	logic aresetn;

	logic [`AXI_ID_W*P-1:0]    s_awid, s_wid, s_bid, s_arid, s_rid;
	logic [`AXI_ADDR_W*P-1:0]  s_awaddr, s_araddr;
	logic [`AXI_LEN_W*P-1:0]   s_awlen, s_arlen;
	logic [`AXI_SIZE_W*P-1:0]  s_awsize, s_arsize;
	logic [`AXI_BURST_W*P-1:0] s_awburst, s_arburst;
	logic [`AXI_DATA_W*P-1:0]  s_wdata, s_rdata;
	logic [`AXI_STRB_W*P-1:0]  s_wstrb;
	logic [`AXI_RESP_W*P-1:0]  s_bresp, s_rresp;
	logic [P-1:0] s_awvalid, s_awready, s_wlast, s_wvalid, s_wready, s_bready, s_bvalid;
	logic [P-1:0] s_arvalid, s_arready, s_rready, s_rlast, s_rvalid;
	logic wr_busy;
	logic rd_busy;

	// Expected SRAM contents
	logic [`AXI_DATA_W-1:0] ref_mem [`SRAM_WORDS];
	logic [31:0] lfsr;
	int          errors;
	int          checks;
	string       test_name;
	// Ports in the order their address handshakes happened
	int          grant_order[$];

	axi_sub_top u_axi_sub_top (.*);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic finish_run;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout in %s: %s did not happen within %0d cycles",
			test_name, what, TIMEOUT);
		finish_run();
	endtask

	task automatic apply_reset;
		#1 aresetn = 1'b0;
		repeat (5) @(posedge aclk);
		#1 aresetn = 1'b1;
		@(posedge aclk);
	endtask

	`include "tb_axi_sub_tasks.svh"

	initial begin
		aresetn = 1'b0;
		{s_awid, s_awaddr, s_awlen, s_awsize, s_awburst, s_awvalid} = '0;
		{s_wid, s_wdata, s_wstrb, s_wlast, s_wvalid, s_bready} = '0;
		{s_arid, s_araddr, s_arlen, s_arsize, s_arburst, s_arvalid, s_rready} = '0;
		lfsr      = 32'h1243;
		errors    = 0;
		checks    = 0;
		test_name = "startup";
		apply_reset();
		test_reset_state();
		test_bursts();
		test_round_robin();
		test_grant_isolation();
		test_independent_sides();
		finish_run();
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
+incdir+sim
verilog/axi_sub_pkg.sv
verilog/axi_bus.sv
verilog/axi_mux.sv
verilog/axi_sram.sv
verilog/axi_sub_top.sv
sim/tb_axi_sub.sv

//--- Bender.yml
package:
  name: axi_sub

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axi_sub_pkg.sv
      - verilog/axi_bus.sv
      - verilog/axi_mux.sv
      - verilog/axi_sram.sv
      - verilog/axi_sub_top.sv
  - target: simulation
    include_dirs:
      - verilog
      - sim
    files:
      - sim/tb_axi_sub.sv
